/* Makefile */
# Verilator build and run for the matmul engine testbench

VERILATOR ?= verilator
TOP       ?= tb_matmul_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/tb_matmul_top.sv */
// test table, reference model, beat driver, check task, watchdog and summary
`timescale 1ns/100ps

module tb_matmul_top;
  import pe_pkg::*;

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 4;
  localparam int NUM_TESTS      = 13;
  localparam int TIMEOUT_MARGIN = 4;
  localparam int JUNK_CYCLES    = 3;    // junk beats offered before a start
  localparam int SAT_MAX        = (1 <<< (DATA_W - 1)) - 1;
  localparam int SAT_MIN        = -(1 <<< (DATA_W - 1));

  logic        clk;
  logic        reset;
  logic        start;
  logic        in_valid;
  logic        in_last;
  op_e         op;
  data_t [MAT_DIM-1:0] a_col;
  data_t [MAT_DIM-1:0] b_row;
  logic        ready;
  logic        busy;
  logic        c_valid;
  row_idx_t    c_row_idx;
  result_row_t c_row;

  // test table with one entry per index
  string t_name  [NUM_TESTS];
  op_e   t_op    [NUM_TESTS];
  int    t_k     [NUM_TESTS];   // matmul beats (element-wise always uses MAT_DIM)
  int    t_a_lo  [NUM_TESTS];
  int    t_a_hi  [NUM_TESTS];
  int    t_b_lo  [NUM_TESTS];
  int    t_b_hi  [NUM_TESTS];
  int    t_stall [NUM_TESTS];   // percent of cycles with in_valid dropped
  bit    t_junk  [NUM_TESTS];   // offer beats while ready is low
  int    n_defined;

  int    a_m   [MAT_DIM][MAX_K];
  int    b_m   [MAX_K][MAT_DIM];
  int    exp_c [MAT_DIM][MAT_DIM];

  string cur_test;
  int    checks;
  int    errors;
  int    passed;
  int    failed;

  matmul_top dut0 (
    .clk         (clk),
    .reset       (reset),
    .i_start     (start),
    .i_in_valid  (in_valid),
    .i_in_last   (in_last),
    .i_op        (op),
    .i_a_col     (a_col),
    .i_b_row     (b_row),
    .o_ready     (ready),
    .o_busy      (busy),
    .o_c_valid   (c_valid),
    .o_c_row_idx (c_row_idx),
    .o_c_row     (c_row)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic add_test(input string name, input op_e test_op, input int k,
                          input int a_lo, input int a_hi, input int b_lo, input int b_hi,
                          input int stall, input bit junk);
    t_name[n_defined]  = name;
    t_op[n_defined]    = test_op;
    t_k[n_defined]     = k;
    t_a_lo[n_defined]  = a_lo;
    t_a_hi[n_defined]  = a_hi;
    t_b_lo[n_defined]  = b_lo;
    t_b_hi[n_defined]  = b_hi;
    t_stall[n_defined] = stall;
    t_junk[n_defined]  = junk;
    n_defined++;
  endtask

  task automatic define_tests();
    n_defined = 0;
    //       name             op          K   A lo    A hi    B lo    B hi   stall junk
    add_test("mm_k4_small",   OP_MATMUL,   4,     -8,      8,     -8,      8,  0, 1'b0);
    add_test("mm_k1_stall",   OP_MATMUL,   1,   -200,    200,   -200,    200, 30, 1'b0);
    add_test("mm_k7_stall",   OP_MATMUL,   7,  -1000,   1000,  -1000,   1000, 40, 1'b0);
    add_test("mm_k16_stall",  OP_MATMUL,  16,  -2000,   2000,  -2000,   2000, 25, 1'b0);
    add_test("mm_sat_pos",    OP_MATMUL,  16,  28000,  32767,  28000,  32767,  0, 1'b0);
    add_test("mm_sat_neg",    OP_MATMUL,   8, -32768, -28000,  28000,  32767, 10, 1'b0);
    add_test("elt_mul_rand",  OP_ELT_MUL,  4, -32768,  32767, -32768,  32767, 30, 1'b0);
    add_test("elt_mul_ext",   OP_ELT_MUL,  4, -32768, -32700, -32768, -32700,  0, 1'b0);
    add_test("elt_add_ext",   OP_ELT_ADD,  4,  30000,  32767,  30000,  32767,  0, 1'b0);
    add_test("elt_add_rand",  OP_ELT_ADD,  4, -32768,  32767, -32768,  32767, 50, 1'b0);
    add_test("elt_sub_ext",   OP_ELT_SUB,  4, -32768, -30000,  30000,  32767, 20, 1'b0);
    add_test("mm_junk",       OP_MATMUL,   5,   -500,    500,   -500,    500, 20, 1'b1);
    add_test("elt_sub_junk",  OP_ELT_SUB,  4, -32768,  32767, -32768,  32767, 20, 1'b1);
  endtask

  function automatic int random_in_range(input int lo, input int hi);
    return lo + int'($urandom % 32'(hi - lo + 1));
  endfunction

  function automatic int clamp_to_data(input longint v);
    if (v > longint'(SAT_MAX)) begin
      return SAT_MAX;
    end else if (v < longint'(SAT_MIN)) begin
      return SAT_MIN;
    end
    return int'(v);
  endfunction

  task automatic fill_operands(input int t);
    for (int i = 0; i < MAT_DIM; i++) begin
      for (int k = 0; k < MAX_K; k++) begin
        a_m[i][k] = random_in_range(t_a_lo[t], t_a_hi[t]);
        b_m[k][i] = random_in_range(t_b_lo[t], t_b_hi[t]);
      end
    end
  endtask

  // behavioral model with an exact wide sum and one clamp per element
  task automatic build_expected(input op_e test_op, input int k);
    longint acc;
    for (int i = 0; i < MAT_DIM; i++) begin
      for (int j = 0; j < MAT_DIM; j++) begin
        acc = 0;
        case (test_op)
          OP_MATMUL: begin
            for (int kk = 0; kk < k; kk++) begin
              acc += longint'(a_m[i][kk]) * longint'(b_m[kk][j]);
            end
          end
          OP_ELT_MUL: acc = longint'(a_m[i][j]) * longint'(b_m[i][j]);
          OP_ELT_ADD: acc = longint'(a_m[i][j]) + longint'(b_m[i][j]);
          default:    acc = longint'(a_m[i][j]) - longint'(b_m[i][j]);
        endcase
        exp_c[i][j] = clamp_to_data(acc);
      end
    end
  endtask

  // matmul beat k is column k of A and row k of B while element-wise goes last to first
  task automatic drive_beat(input op_e test_op, input int beat);
    for (int i = 0; i < MAT_DIM; i++) begin
      if (test_op == OP_MATMUL) begin
        a_col[i] = data_t'(a_m[i][beat]);
        b_row[i] = data_t'(b_m[beat][i]);
      end else begin
        a_col[i] = data_t'(a_m[i][MAT_DIM-1-beat]);
        b_row[i] = data_t'(b_m[MAT_DIM-1-beat][i]);
      end
    end
  endtask

  task automatic drive_idle(input bit junk);
    if (junk) begin
      for (int i = 0; i < MAT_DIM; i++) begin
        a_col[i] = data_t'($urandom);
        b_row[i] = data_t'($urandom);
      end
      in_valid = 1'b1;
      in_last  = 1'($urandom % 2);
    end else begin
      in_valid = 1'b0;
      in_last  = 1'b0;
    end
  endtask

  task automatic check_value(input string what, input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
    end
  endtask

  task automatic run_test(input int t);
    int nbeats;
    int taken;
    int errors_before;
    bit stall;
    cur_test      = t_name[t];
    errors_before = errors;
    nbeats        = (t_op[t] == OP_MATMUL) ? t_k[t] : MAT_DIM;
    fill_operands(t);
    build_expected(t_op[t], nbeats);

    repeat (t_junk[t] ? JUNK_CYCLES : 0) begin
      @(negedge clk);
      drive_idle(1'b1);
    end
    @(negedge clk);
    drive_idle(t_junk[t]);
    start = 1'b1;
    op    = t_op[t];

    taken = 0;
    while (taken < nbeats) begin
      @(negedge clk);
      start = 1'b0;
      stall = ($urandom % 100) < t_stall[t];
      drive_beat(t_op[t], taken);
      in_valid = !stall;
      // element-wise jobs must ignore the last flag
      in_last  = (t_op[t] == OP_MATMUL) ? (taken == nbeats - 1) : 1'($urandom % 2);
      if (!stall && ready) begin
        taken++;   // beat held until ready sees it
      end
    end

    do begin
      @(negedge clk);
      drive_idle(t_junk[t]);
    end while (!c_valid);

    for (int row = 0; row < MAT_DIM; row++) begin
      if (row > 0) begin
        @(negedge clk);
        drive_idle(t_junk[t]);
        check_value("c_valid during readout", 1, 32'(c_valid));
      end
      check_value("busy during readout", 1, 32'(busy));
      check_value("row index", row, 32'(c_row_idx));
      for (int col = 0; col < MAT_DIM; col++) begin
        check_value($sformatf("c[%0d][%0d]", row, col), exp_c[row][col], 32'(c_row[col]));
      end
    end
    @(negedge clk);
    drive_idle(1'b0);
    check_value("c_valid after readout", 0, 32'(c_valid));
    check_value("busy after readout", 0, 32'(busy));

    if (errors == errors_before) begin
      passed++;
      $display("test %-14s done, %2d beats, all results match", cur_test, nbeats);
    end else begin
      failed++;
      $display("test %-14s done, %2d beats, %0d mismatches", cur_test, nbeats,
               errors - errors_before);
    end
  endtask

  // cycle budget from the table where a stalled job stretches by 100/(100-stall)
  function automatic int timeout_cycles();
    int total;
    int beats;
    total = RESET_CYCLES + 10;
    for (int t = 0; t < NUM_TESTS; t++) begin
      beats = (t_op[t] == OP_MATMUL) ? t_k[t] : MAT_DIM;
      total += beats * 100 / (100 - t_stall[t]) + FLUSH_CYCLES + MAT_DIM + 4;
      total += t_junk[t] ? JUNK_CYCLES : 0;
    end
    return total * TIMEOUT_MARGIN;
  endfunction

  initial begin
    int budget;
    #1;   // table is filled at time 0
    budget = timeout_cycles();
    #(budget * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, a job did not finish in time", budget);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(87));
    clk      = 1'b0;
    reset    = 1'b1;
    start    = 1'b0;
    in_valid = 1'b0;
    in_last  = 1'b0;
    op       = OP_MATMUL;
    a_col    = '0;
    b_row    = '0;
    checks   = 0;
    errors   = 0;
    passed   = 0;
    failed   = 0;
    define_tests();

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset    = 1'b0;
    cur_test = "reset";
    check_value("ready after reset", 0, 32'(ready));
    check_value("busy after reset", 0, 32'(busy));
    check_value("c_valid after reset", 0, 32'(c_valid));

    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    repeat (2) @(negedge clk);

    $display("summary: %0d tests, %0d passed, %0d failed, %0d of %0d checks failed",
             NUM_TESTS, passed, failed, errors, checks);
    if (errors == 0 && failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* source/matmul_ctrl.sv */
// matmul_ctrl: job FSM for stream, flush or element-wise compute, and row readout
`timescale 1ns/100ps

module matmul_ctrl (
  input  logic             clk,
  input  logic             reset,
  input  logic             i_start,
  input  logic             i_in_valid,
  input  logic             i_in_last,
  input  pe_pkg::op_e      i_op,
  output logic             o_ready,
  output logic             o_clear,
  output logic             o_elt_mode,
  output logic             o_compute,
  output pe_pkg::op_e      o_op,
  output logic             o_c_valid,
  output pe_pkg::row_idx_t o_rd_row,
  output logic             o_busy
);
  import pe_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    STREAM,
    FLUSH,
    COMPUTE,
    READOUT
  } state_e;

  typedef logic [$clog2(MAX_K)-1:0]        beat_cnt_t;
  typedef logic [$clog2(FLUSH_CYCLES)-1:0] wait_cnt_t;

  state_e    state;
  op_e       op_q;       // latched at start
  beat_cnt_t beat_cnt;
  wait_cnt_t wait_cnt;   // flush, compute and readout share it
  logic      take;
  logic      last_beat;

  assign take = o_ready && i_in_valid;

  // element-wise streams end on the fourth beat, matmul on i_in_last or MAX_K
  assign last_beat = o_elt_mode ? (beat_cnt == beat_cnt_t'(MAT_DIM - 1))
                                : (i_in_last || beat_cnt == beat_cnt_t'(MAX_K - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      op_q     <= OP_MATMUL;
      beat_cnt <= '0;
      wait_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (i_start) begin
            state    <= STREAM;
            op_q     <= i_op;
            beat_cnt <= '0;
          end
        end
        STREAM: begin
          if (take) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              state    <= o_elt_mode ? COMPUTE : FLUSH;
              wait_cnt <= '0;
            end
          end
        end
        FLUSH: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == wait_cnt_t'(FLUSH_CYCLES - 1)) begin
            state    <= READOUT;
            wait_cnt <= '0;
          end
        end
        COMPUTE: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == wait_cnt_t'(PE_LATENCY)) begin   // PE_LATENCY+1 cycles
            state    <= READOUT;
            wait_cnt <= '0;
          end
        end
        READOUT: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == wait_cnt_t'(MAT_DIM - 1)) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign o_ready    = (state == STREAM);
  assign o_clear    = (state == IDLE) && i_start;
  assign o_op       = op_q;
  assign o_elt_mode = (op_q != OP_MATMUL);
  assign o_c_valid  = (state == READOUT);
  assign o_rd_row   = wait_cnt[$bits(row_idx_t)-1:0];
  assign o_busy     = (state != IDLE);

  // an element-wise stall also freezes the grid, so a bubble never shifts in
  assign o_compute = (state == COMPUTE) || ((state == STREAM) && o_elt_mode && !take);

  no_ready_in_readout: assert property (@(posedge clk) disable iff (reset)
    !(o_ready && o_c_valid));

endmodule

/* source/matmul_top.sv */
// matmul_top: control FSM, operand skew, systolic array and row output
`timescale 1ns/100ps

module matmul_top (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 i_start,
  input  logic                                 i_in_valid,
  input  logic                                 i_in_last,
  input  pe_pkg::op_e                          i_op,
  input  pe_pkg::data_t [pe_pkg::MAT_DIM-1:0] i_a_col,
  input  pe_pkg::data_t [pe_pkg::MAT_DIM-1:0] i_b_row,
  output logic                                 o_ready,
  output logic                                 o_busy,
  output logic                                 o_c_valid,
  output pe_pkg::row_idx_t                     o_c_row_idx,
  output pe_pkg::result_row_t                  o_c_row
);
  import pe_pkg::*;

  logic         clear_acc;
  logic         elt_mode;
  logic         elt_compute;
  op_e          elt_op;
  row_idx_t     rd_row;
  logic         beat_take;   // beat accepted this cycle
  operand_vec_t a_west;
  operand_vec_t b_north;

  assign beat_take   = i_in_valid && o_ready;
  assign o_c_row_idx = rd_row;

  matmul_ctrl ctrl0 (
    .clk        (clk),
    .reset      (reset),
    .i_start    (i_start),
    .i_in_valid (i_in_valid),
    .i_in_last  (i_in_last),
    .i_op       (i_op),
    .o_ready    (o_ready),
    .o_clear    (clear_acc),
    .o_elt_mode (elt_mode),
    .o_compute  (elt_compute),
    .o_op       (elt_op),
    .o_c_valid  (o_c_valid),
    .o_rd_row   (rd_row),
    .o_busy     (o_busy)
  );

  operand_skew skew0 (
    .clk        (clk),
    .reset      (reset),
    .i_a_col    (i_a_col),
    .i_b_row    (i_b_row),
    .i_valid    (beat_take),
    .i_elt_mode (elt_mode),
    .o_a_west   (a_west),
    .o_b_north  (b_north)
  );

  systolic_array array0 (
    .clk        (clk),
    .reset      (reset),
    .i_a_west   (a_west),
    .i_b_north  (b_north),
    .i_clear    (clear_acc),
    .i_elt_mode (elt_mode),
    .i_compute  (elt_compute),
    .i_op       (elt_op),
    .i_rd_row   (rd_row),
    .o_c_row    (o_c_row)
  );

endmodule

/* source/operand_skew.sv */
// per-lane delay lines that stagger A rows and B columns for the systolic wavefront
`timescale 1ns/100ps

module operand_skew (
  input  logic                                 clk,
  input  logic                                 reset,
  input  pe_pkg::data_t [pe_pkg::MAT_DIM-1:0] i_a_col,
  input  pe_pkg::data_t [pe_pkg::MAT_DIM-1:0] i_b_row,
  input  logic                                 i_valid,
  input  logic                                 i_elt_mode,
  output pe_pkg::operand_vec_t                 o_a_west,
  output pe_pkg::operand_vec_t                 o_b_north
);
  import pe_pkg::*;

  for (genvar i = 0; i < MAT_DIM; i++) begin : g_lane
    pe_operand_t [1:0] lane_in;    // [0] A row i, [1] B column i

    assign lane_in[0] = '{valid: i_valid, data: i_a_col[i]};
    assign lane_in[1] = '{valid: i_valid, data: i_b_row[i]};

    if (i == 0) begin : g_direct
      assign o_a_west[i]  = lane_in[0];
      assign o_b_north[i] = lane_in[1];
    end else begin : g_chain
      pe_operand_t [1:0] chain [i];   // i stages

      always_ff @(posedge clk) begin
        chain[0] <= lane_in;
        for (int s = 1; s < i; s++) begin
          chain[s] <= chain[s-1];
        end
        if (reset) begin
          for (int s = 0; s < i; s++) begin
            chain[s][0].valid <= 1'b0;
            chain[s][1].valid <= 1'b0;
          end
        end
      end

      // element-wise beats skip the stagger and fill the whole grid straight
      assign o_a_west[i]  = i_elt_mode ? lane_in[0] : chain[i-1][0];
      assign o_b_north[i] = i_elt_mode ? lane_in[1] : chain[i-1][1];
    end
  end

endmodule

/* source/pe_pkg.sv */
// pe_pkg: array size, data widths, operand and row types, operation encoding
package pe_pkg;

  localparam int MAT_DIM    = 4;    // array edge
  localparam int DATA_W     = 16;   // operand and result width
  localparam int ACC_W      = 36;   // sixteen full-scale products fit
  localparam int MAX_K      = 16;   // longest matmul stream
  localparam int PE_LATENCY = 3;    // operand register to saturated result

  // the last beat needs 2*(MAT_DIM-1) cycles to reach the far corner
  localparam int FLUSH_CYCLES = 2 * (MAT_DIM - 1) + PE_LATENCY + 1;

  typedef logic signed [DATA_W-1:0]  data_t;
  typedef logic signed [ACC_W-1:0]   acc_t;
  typedef logic [$clog2(MAT_DIM)-1:0] row_idx_t;

  // op[1:0]
  //   00 matrix multiply
  //   01 element-wise multiply
  //   10 element-wise add
  //   11 element-wise subtract
  typedef enum logic [1:0] {
    OP_MATMUL  = 2'b00,
    OP_ELT_MUL = 2'b01,
    OP_ELT_ADD = 2'b10,
    OP_ELT_SUB = 2'b11
  } op_e;

  // one operand on its way east (A) or south (B)
  typedef struct packed {
    logic  valid;
    data_t data;
  } pe_operand_t;

  // one beat of A or B, lane i feeds row i or column i
  typedef pe_operand_t [MAT_DIM-1:0] operand_vec_t;

  // one row of C, element j is column j
  typedef data_t [MAT_DIM-1:0] result_row_t;

endpackage

/* source/processing_element.sv */
// processing_element: one array cell with east / south operand registers and its sat_mac
`timescale 1ns/100ps

module processing_element (
  input  logic                clk,
  input  logic                reset,
  input  pe_pkg::pe_operand_t i_a_in,
  input  pe_pkg::pe_operand_t i_b_in,
  input  logic                i_clear,
  input  logic                i_elt_mode,
  input  logic                i_compute,
  input  pe_pkg::op_e         i_op,
  output pe_pkg::pe_operand_t o_a_out,
  output pe_pkg::pe_operand_t o_b_out,
  output pe_pkg::data_t       o_result
);
  import pe_pkg::*;

  pe_operand_t a_q;
  pe_operand_t b_q;
  logic        mac_valid;

  // operands shift every cycle, compute freezes them in place
  always_ff @(posedge clk) begin
    if (!i_compute) begin
      a_q <= i_a_in;
      b_q <= i_b_in;
    end
    if (reset || i_clear) begin
      a_q.valid <= 1'b0;
      b_q.valid <= 1'b0;
    end
  end

  assign o_a_out = a_q;
  assign o_b_out = b_q;

  // accumulate only on matched pairs, element-wise results are loaded instead
  assign mac_valid = a_q.valid && b_q.valid && !i_elt_mode;

  sat_mac mac0 (
    .clk       (clk),
    .reset     (reset),
    .i_a       (a_q.data),
    .i_b       (b_q.data),
    .i_valid   (mac_valid),
    .i_clear   (i_clear),
    .i_op      (i_op),
    .i_compute (i_compute),
    .o_result  (o_result)
  );

  held_during_compute: assert property (@(posedge clk) disable iff (reset)
    i_compute |=> $stable(a_q) && $stable(b_q));

endmodule

/* source/sat_mac.sv */
// sat_mac: pipelined multiply / add / subtract with wide accumulator and saturating output
`timescale 1ns/100ps

module sat_mac (
  input  logic            clk,
  input  logic            reset,
  input  pe_pkg::data_t   i_a,
  input  pe_pkg::data_t   i_b,
  input  logic            i_valid,
  input  logic            i_clear,
  input  pe_pkg::op_e     i_op,
  input  logic            i_compute,
  output pe_pkg::data_t   o_result
);
  import pe_pkg::*;

  data_t                     a_q;
  data_t                     b_q;
  logic                      valid1_q;
  logic signed [2*DATA_W-1:0] product;
  acc_t                      stage_d;
  acc_t                      stage_q;   // product, sum or difference
  logic                      valid2_q;
  acc_t                      acc_q;
  data_t                     acc_sat;
  data_t                     out_q;

  assign product = a_q * b_q;

  // the element-wise op picks what enters the accumulator stage
  always_comb begin
    case (i_op)
      OP_ELT_ADD: stage_d = acc_t'(a_q) + acc_t'(b_q);
      OP_ELT_SUB: stage_d = acc_t'(a_q) - acc_t'(b_q);
      default:    stage_d = acc_t'(product);
    endcase
  end

  // payload pipeline
  always_ff @(posedge clk) begin
    a_q     <= i_a;
    b_q     <= i_b;
    stage_q <= stage_d;
    out_q   <= acc_sat;
  end

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      valid1_q <= 1'b0;
      valid2_q <= 1'b0;
      acc_q    <= '0;
    end else begin
      valid1_q <= i_valid;
      valid2_q <= valid1_q;
      if (i_compute) begin
        acc_q <= stage_q;   // element-wise load
      end else if (valid2_q) begin
        acc_q <= acc_q + stage_q;
      end
    end
  end

  // clamp to the data_t range, in range when all upper bits match the sign
  always_comb begin
    if (&acc_q[ACC_W-1:DATA_W-1] || ~|acc_q[ACC_W-1:DATA_W-1]) begin
      acc_sat = acc_q[DATA_W-1:0];
    end else if (acc_q[ACC_W-1]) begin
      acc_sat = {1'b1, {(DATA_W-1){1'b0}}};   // -32768
    end else begin
      acc_sat = {1'b0, {(DATA_W-1){1'b1}}};   // +32767
    end
  end

  assign o_result = out_q;

  // the controller only raises compute for element-wise jobs
  compute_not_matmul: assert property (@(posedge clk) disable iff (reset)
    !(i_compute && i_op == OP_MATMUL));

endmodule

/* source/systolic_array.sv */
// systolic_array: MAT_DIM x MAT_DIM grid of processing elements and the result row select
`timescale 1ns/100ps

module systolic_array (
  input  logic                 clk,
  input  logic                 reset,
  input  pe_pkg::operand_vec_t i_a_west,
  input  pe_pkg::operand_vec_t i_b_north,
  input  logic                 i_clear,
  input  logic                 i_elt_mode,
  input  logic                 i_compute,
  input  pe_pkg::op_e          i_op,
  input  pe_pkg::row_idx_t     i_rd_row,
  output pe_pkg::result_row_t  o_c_row
);
  import pe_pkg::*;

  pe_operand_t a_h [MAT_DIM][MAT_DIM+1];   // column MAT_DIM is the east edge
  pe_operand_t b_v [MAT_DIM+1][MAT_DIM];   // row MAT_DIM is the south edge
  result_row_t pe_result [MAT_DIM];

  for (genvar i = 0; i < MAT_DIM; i++) begin : g_row
    assign a_h[i][0] = i_a_west[i];
    assign b_v[0][i] = i_b_north[i];

    for (genvar j = 0; j < MAT_DIM; j++) begin : g_col
      processing_element pe0 (
        .clk        (clk),
        .reset      (reset),
        .i_a_in     (a_h[i][j]),
        .i_b_in     (b_v[i][j]),
        .i_clear    (i_clear),
        .i_elt_mode (i_elt_mode),
        .i_compute  (i_compute),
        .i_op       (i_op),
        .o_a_out    (a_h[i][j+1]),
        .o_b_out    (b_v[i+1][j]),
        .o_result   (pe_result[i][j])
      );
    end
  end

  assign o_c_row = pe_result[i_rd_row];   // one row per readout cycle

  // in matmul mode the skew keeps A and B wavefronts aligned, so every cell
  // on the east and south edges holds either a matched pair or two bubbles
  for (genvar e = 0; e < MAT_DIM; e++) begin : g_edge_chk
    east_edge_aligned: assert property (@(posedge clk) disable iff (reset || i_elt_mode)
      a_h[e][MAT_DIM].valid == b_v[e+1][MAT_DIM-1].valid);

    south_edge_aligned: assert property (@(posedge clk) disable iff (reset || i_elt_mode)
      b_v[MAT_DIM][e].valid == a_h[MAT_DIM-1][e+1].valid);
  end

endmodule

/* src.f */
source/pe_pkg.sv
source/sat_mac.sv
source/processing_element.sv
source/operand_skew.sv
source/systolic_array.sv
source/matmul_ctrl.sv
source/matmul_top.sv
bench/tb_matmul_top.sv
